//--- sim.f
rtl/policer_pkg.sv
rtl/policer_regs.sv
rtl/policer_header_decode.sv
rtl/policer_bucket.sv
rtl/policer_verdict_merge.sv
rtl/policer_top.sv
testbench/policer_assertions.sv
testbench/policer_tb.sv

//--- Makefile
# Verilator build and run for the policer testbench.

TOP = policer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/policer_tb.sv
`timescale 1ns/1ps
// Policer testbench.
// Drives APB and packet traffic, models the leaky buckets and checks every output beat.
module policer_tb;

    localparam int test_beats  = 400;                        // Upper bound on stream beats.
    localparam int clk_period  = 20;
    localparam longint timeout = (test_beats * 40 + 1000) * clk_period;

    logic        packet_in;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_data;
    logic        in_last;
    logic [1:0]  in_port;
    logic [15:0] in_length;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_data;
    logic        out_last;
    logic [1:0]  out_port;
    logic        out_drop;

    int          errors;
    int          accepted_beats;
    logic        stall_en;
    logic        tb_in_packet;                                // Next input beat continues a packet.
    logic        cur_drop;

    // Reference bucket state in whole bytes.
    logic [3:0]  model_en;
    logic [3:0]  model_leak_big;
    int          model_level [4];
    int          model_thr [4];
    logic [15:0] model_drops [4];

    logic [31:0] exp_data [$];
    logic        exp_last [$];
    logic [1:0]  exp_port [$];
    logic        exp_drop [$];

    policer_top i_policer_top (.*);

    always #(clk_period / 2) packet_in = ~packet_in;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] got);
        assert (exp === got) else begin
            errors++;
            $display("ERROR %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // Bucket rule for the current packet start.
    function automatic logic predict_drop(int p, int len);
        if (!model_en[p]) return 1'b0;                        // Disabled port passes.
        if (model_leak_big[p]) return len > model_thr[p];     // Bucket empty again.
        if (model_level[p] + len > model_thr[p]) return 1'b1;
        model_level[p] += len;
        return 1'b0;
    endfunction

    // Output check first, then record the accepted input beat.
    always @(posedge packet_in) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_data.size() != 0) else begin
                errors++;
                $display("Output beat appeared with no input beat waiting at %0t", $time);
            end
            if (exp_data.size() != 0) begin
                compare_value("out_data", exp_data.pop_front(), out_data);
                compare_value("out_last", 32'(exp_last.pop_front()), 32'(out_last));
                compare_value("out_port", 32'(exp_port.pop_front()), 32'(out_port));
                compare_value("out_drop", 32'(exp_drop.pop_front()), 32'(out_drop));
            end
        end
        if (!rst && in_valid && in_ready) begin
            if (!tb_in_packet) begin
                cur_drop = predict_drop(in_port, in_length);
                if (cur_drop) model_drops[in_port]++;         // Wraps like the counter.
            end
            exp_data.push_back(in_data);
            exp_last.push_back(in_last);
            exp_port.push_back(in_port);
            exp_drop.push_back(cur_drop);
            tb_in_packet = ~in_last;
            accepted_beats++;
        end
    end

    // Back-pressure on the output.
    always @(negedge packet_in) begin
        out_ready <= stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apb_write(logic [7:0] addr, logic [31:0] data, logic exp_err);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge packet_in);
        penable = 1'b1;                                        // Access phase.
        @(posedge packet_in);
        compare_value("pslverr", 32'(exp_err), 32'(pslverr));
        @(negedge packet_in);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(logic [7:0] addr, logic [31:0] exp, logic exp_err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge packet_in);
        penable = 1'b1;
        @(posedge packet_in);
        compare_value("pslverr", 32'(exp_err), 32'(pslverr));
        if (!exp_err) compare_value("prdata", exp, prdata);
        @(negedge packet_in);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Configures one port and mirrors it into the model.
    task automatic config_port(int p, logic en, logic [31:0] leak, int thr);
        apb_write(8'(p * 16 + 4), leak, 1'b0);
        apb_write(8'(p * 16 + 8), 32'(thr), 1'b0);
        apb_write(8'(p * 16), 32'(en), 1'b0);
        apb_read(8'(p * 16), 32'(en), 1'b0);
        apb_read(8'(p * 16 + 4), leak, 1'b0);
        apb_read(8'(p * 16 + 8), 32'(thr), 1'b0);
        model_en[p]       = en;
        model_leak_big[p] = (leak != 0);
        model_thr[p]      = thr;
    endtask

    task automatic send_packet(logic [1:0] p, logic [15:0] len, int beats);
        int seen;
        for (int b = 0; b < beats; b++) begin
            in_valid  = 1'b1;
            in_data   = $urandom();
            in_last   = (b == beats - 1);
            in_port   = p;
            in_length = len;
            seen      = accepted_beats;
            do @(negedge packet_in); while (accepted_beats == seen);
        end
        in_valid = 1'b0;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) @(negedge packet_in);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h701));
        packet_in = 1'b0;
        rst = 1'b1;
        {paddr, psel, penable, pwrite, pwdata} = '0;
        {in_valid, in_data, in_last, in_port, in_length} = '0;
        out_ready = 1'b1;
        stall_en = 1'b0;
        errors = 0;
        accepted_beats = 0;
        tb_in_packet = 1'b0;
        cur_drop = 1'b0;
        model_en = '0;
        model_leak_big = '0;
        for (int p = 0; p < 4; p++) begin
            model_level[p] = 0;
            model_thr[p]   = 0;
            model_drops[p] = '0;
        end
        repeat (16) @(posedge packet_in);
        @(negedge packet_in);
        rst = 1'b0;

        config_port(0, 1'b1, 32'h0, 100);                      // Leak zero, small bucket.
        config_port(1, 1'b0, 32'h0, 10);                       // Disabled.
        config_port(2, 1'b1, 32'h10000, 200);                  // Drains 256 bytes per cycle.
        config_port(3, 1'b1, 32'h0, 1000);
        apb_write(8'h0c, 32'h5, 1'b1);                         // Drops are read-only.
        apb_read(8'h40, 32'h0, 1'b1);                          // Past the last window.
        apb_write(8'h84, 32'h1, 1'b1);

        // Pass-through, fill-up and disabled port.
        for (int i = 0; i < 4; i++) begin
            send_packet(2'd0, 16'd40, 1 + i % 3);
            send_packet(2'd3, 16'd30, 2);
            send_packet(2'd1, 16'd5000, 3);
        end
        // Widely spaced packets on a leaking port.
        for (int i = 0; i < 5; i++) begin
            send_packet(2'd2, 16'd150, 2);
            idle(6);
        end

        // Random traffic under back-pressure.
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            int p;
            p = $urandom_range(3);
            if (p == 2) p = 3;
            send_packet(2'(p), 16'($urandom_range(200, 1)), $urandom_range(4, 1));
        end
        while (exp_data.size() != 0) @(negedge packet_in);
        stall_en = 1'b0;
        idle(4);

        for (int p = 0; p < 4; p++) begin
            apb_read(8'(p * 16 + 12), 32'(model_drops[p]), 1'b0);
        end

        errors += i_policer_top.i_policer_assertions.failures;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(timeout);
        $display("Watchdog expired before the test sequence finished, errors so far: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/policer_assertions.sv
`timescale 1ns/1ps
// Policer protocol checks bound to the top level.
module policer_assertions (
    input logic        packet_in,
    input logic        rst,
    input logic        pready,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] out_data,
    input logic        out_last,
    input logic [1:0]  out_port,
    input logic        out_drop
);

    int failures = 0;   // Failed property attempts.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset behavior
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    reset_quiet: assert property (@(posedge packet_in)
        rst |=> (!out_valid && !in_ready))
        else begin
            failures++;
            $error("Stream handshake active during reset.");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stream stability
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stall_hold: assert property (@(posedge packet_in) disable iff (rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_last)
             && $stable(out_port) && $stable(out_drop)))
        else begin
            failures++;
            $error("Output beat changed while stalled.");
        end

    // No wait states on APB.
    apb_ready: assert property (@(posedge packet_in) pready)
        else begin
            failures++;
            $error("pready went low.");
        end

endmodule

bind policer_top policer_assertions i_policer_assertions (.*);

//--- rtl/policer_top.sv
`timescale 1ns/1ps
// Per-ingress-port traffic policer.
// Marks packets that overflow their port's leaky bucket; APB configures and reads counters.
module policer_top (
    input  logic                               packet_in,
    input  logic                               rst,
    input  logic [policer_pkg::addr_w-1:0]     paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [policer_pkg::data_w-1:0]     in_data,
    input  logic                               in_last,
    input  logic [policer_pkg::port_w-1:0]     in_port,
    input  logic [policer_pkg::length_w-1:0]   in_length,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [policer_pkg::data_w-1:0]     out_data,
    output logic                               out_last,
    output logic [policer_pkg::port_w-1:0]     out_port,
    output logic                               out_drop
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [policer_pkg::num_ports-1:0]                           enable;
    logic [policer_pkg::num_ports-1:0][policer_pkg::level_w-1:0]  leak;
    logic [policer_pkg::num_ports-1:0][policer_pkg::length_w-1:0] threshold;
    logic [policer_pkg::num_ports-1:0][policer_pkg::count_w-1:0]  drop_count;

    logic                                advance;
    logic                                s1_valid;
    logic [policer_pkg::data_w-1:0]      s1_data;
    logic                                s1_last;
    logic [policer_pkg::port_w-1:0]      s1_port;
    logic                                s1_first;
    logic [policer_pkg::num_ports-1:0]   charge;
    logic [policer_pkg::length_w-1:0]    charge_length;
    logic [policer_pkg::num_ports-1:0]   drop;

    policer_regs i_policer_regs (
        .packet_in (packet_in), .rst (rst),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .drop_count (drop_count),
        .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .enable (enable), .leak (leak), .threshold (threshold)
    );

    policer_header_decode i_policer_header_decode (
        .packet_in (packet_in), .rst (rst),
        .in_valid (in_valid), .in_data (in_data), .in_last (in_last),
        .in_port (in_port), .in_length (in_length), .advance (advance),
        .in_ready (in_ready), .s1_valid (s1_valid), .s1_data (s1_data),
        .s1_last (s1_last), .s1_port (s1_port), .s1_first (s1_first),
        .charge (charge), .charge_length (charge_length)
    );

    // One bucket per ingress port.
    for (genvar i = 0; i < policer_pkg::num_ports; i++) begin : g_bucket
        policer_bucket i_policer_bucket (
            .packet_in (packet_in), .rst (rst),
            .enable (enable[i]), .leak (leak[i]), .threshold (threshold[i]),
            .charge (charge[i]), .charge_length (charge_length),
            .drop (drop[i])
        );
    end

    policer_verdict_merge i_policer_verdict_merge (
        .packet_in (packet_in), .rst (rst),
        .s1_valid (s1_valid), .s1_data (s1_data), .s1_last (s1_last),
        .s1_port (s1_port), .s1_first (s1_first), .drop (drop),
        .out_ready (out_ready), .advance (advance),
        .out_valid (out_valid), .out_data (out_data), .out_last (out_last),
        .out_port (out_port), .out_drop (out_drop), .drop_count (drop_count)
    );

endmodule

//--- rtl/policer_verdict_merge.sv
`timescale 1ns/1ps
// Policer output stage.
// Applies the packet verdict to every beat and counts dropped packets per port.
module policer_verdict_merge (
    input  logic                                 packet_in,
    input  logic                                 rst,
    input  logic                                 s1_valid,
    input  logic [policer_pkg::data_w-1:0]       s1_data,
    input  logic                                 s1_last,
    input  logic [policer_pkg::port_w-1:0]       s1_port,
    input  logic                                 s1_first,
    input  logic [policer_pkg::num_ports-1:0]    drop,
    input  logic                                 out_ready,
    output logic                                 advance,
    output logic                                 out_valid,
    output logic [policer_pkg::data_w-1:0]       out_data,
    output logic                                 out_last,
    output logic [policer_pkg::port_w-1:0]       out_port,
    output logic                                 out_drop,
    output logic [policer_pkg::num_ports-1:0][policer_pkg::count_w-1:0] drop_count
);

    logic active;      // Low until the first edge out of reset.
    logic fresh;       // A first beat just entered; its verdict is on drop.
    logic held_drop;   // Verdict of the packet in flight.
    logic verdict;

    assign advance  = active & (out_ready | ~out_valid);
    assign verdict  = drop[out_port];
    assign out_drop = fresh ? verdict : held_drop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in) begin
        if (rst) begin
            active     <= 1'b0;
            out_valid  <= 1'b0;
            fresh      <= 1'b0;
            held_drop  <= 1'b0;
            drop_count <= '0;
        end else begin
            active <= 1'b1;
            fresh  <= 1'b0;                                // Verdict lasts one cycle.
            if (fresh) begin
                held_drop <= verdict;                      // Kept for the rest of the packet.
            end
            if (fresh && verdict) begin
                drop_count[out_port] <= drop_count[out_port] + 1'b1; // Wraps.
            end
            if (advance) begin
                out_valid <= s1_valid;
                fresh     <= s1_valid & s1_first;
            end
        end
    end

    // Output beat payload.
    always_ff @(posedge packet_in) begin
        if (advance) begin
            out_data <= s1_data;
            out_last <= s1_last;
            out_port <= s1_port;
        end
    end

endmodule

//--- rtl/policer_bucket.sv
`timescale 1ns/1ps
// Policer leaky bucket for one ingress port.
// Leaks every cycle, charges on packet start and registers a drop verdict.
module policer_bucket (
    input  logic                               packet_in,
    input  logic                               rst,
    input  logic                               enable,
    input  logic [policer_pkg::level_w-1:0]    leak,
    input  logic [policer_pkg::length_w-1:0]   threshold,
    input  logic                               charge,
    input  logic [policer_pkg::length_w-1:0]   charge_length,
    output logic                               drop
);

    logic [policer_pkg::level_w-1:0]   level;     // Fixed point, frac_w fraction bits.
    logic [policer_pkg::level_w-1:0]   leaked;
    logic [policer_pkg::length_w:0]    demand;
    logic                              over;
    logic [policer_pkg::level_w:0]     filled;
    logic [policer_pkg::level_w:0]     refilled;
    logic [policer_pkg::level_w-1:0]   charged;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next-level arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign leaked = (level > leak) ? level - leak : '0;      // Floored at zero.

    // Whole part of the level plus the new packet, against the threshold.
    assign demand = {1'b0, level[policer_pkg::level_w-1:policer_pkg::frac_w]}
                  + {1'b0, charge_length};
    assign over   = demand > {1'b0, threshold};

    // Packet length moved up into the fixed-point grid.
    assign filled   = {1'b0, level}
                    + {1'b0, charge_length, {policer_pkg::frac_w{1'b0}}};
    assign refilled = filled - {1'b0, leak};
    assign charged  = (filled > {1'b0, leak}) ? refilled[policer_pkg::level_w-1:0] : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Level and verdict
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in) begin
        if (rst) begin
            level <= '0;
            drop  <= 1'b0;
        end else if (!enable) begin
            level <= '0;                               // Disabled port always passes.
            drop  <= 1'b0;
        end else if (charge && over) begin
            level <= leaked;                           // Dropped packet is not charged.
            drop  <= 1'b1;
        end else if (charge) begin
            level <= charged;
            drop  <= 1'b0;
        end else begin
            level <= leaked;
            drop  <= 1'b0;
        end
    end

endmodule

//--- rtl/policer_header_decode.sv
`timescale 1ns/1ps
// Policer input stage.
// Registers each beat, finds packet starts and issues one-hot bucket charges.
module policer_header_decode (
    input  logic                                 packet_in,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  logic [policer_pkg::data_w-1:0]       in_data,
    input  logic                                 in_last,
    input  logic [policer_pkg::port_w-1:0]       in_port,
    input  logic [policer_pkg::length_w-1:0]     in_length,
    input  logic                                 advance,
    output logic                                 in_ready,
    output logic                                 s1_valid,
    output logic [policer_pkg::data_w-1:0]       s1_data,
    output logic                                 s1_last,
    output logic [policer_pkg::port_w-1:0]       s1_port,
    output logic                                 s1_first,
    output logic [policer_pkg::num_ports-1:0]    charge,
    output logic [policer_pkg::length_w-1:0]     charge_length
);

    logic in_packet;   // A packet is open; its next beat is not a start.
    logic accept;

    assign in_ready = advance;
    assign accept   = in_valid & advance;

    // Stage-1 control.
    always_ff @(posedge packet_in) begin
        if (rst) begin
            in_packet <= 1'b0;
            s1_valid  <= 1'b0;
            s1_first  <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s1_first <= in_valid & ~in_packet;
            if (accept) begin
                in_packet <= ~in_last;                 // Last beat closes the packet.
            end
        end
    end

    // Beat payload; sideband is latched only on a start and held for the packet.
    always_ff @(posedge packet_in) begin
        if (accept) begin
            s1_data <= in_data;
            s1_last <= in_last;
            if (!in_packet) begin
                s1_port       <= in_port;
                charge_length <= in_length;
            end
        end
    end

    // One charge per packet, when its first beat leaves stage 1.
    always_comb begin
        charge = '0;
        if (s1_valid && s1_first && advance) begin
            charge[s1_port] = 1'b1;
        end
    end

endmodule

//--- rtl/policer_regs.sv
`timescale 1ns/1ps
// Policer APB register file.
// Holds per-port enable, leak and threshold and returns the drop counters.
module policer_regs (
    input  logic                                     packet_in,
    input  logic                                     rst,
    input  logic [policer_pkg::addr_w-1:0]           paddr,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [31:0]                              pwdata,
    input  logic [policer_pkg::num_ports-1:0][policer_pkg::count_w-1:0] drop_count,
    output logic [31:0]                              prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    output logic [policer_pkg::num_ports-1:0]        enable,
    output logic [policer_pkg::num_ports-1:0][policer_pkg::level_w-1:0] leak,
    output logic [policer_pkg::num_ports-1:0][policer_pkg::length_w-1:0] threshold
);

    logic                               access;
    logic                               in_range;
    logic [policer_pkg::port_w-1:0]     port_idx;
    logic [policer_pkg::stride_w-1:0]   offset;
    logic                               wr_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign access   = psel & penable;                  // Access phase.
    assign in_range = paddr < policer_pkg::regs_top;
    assign port_idx = paddr[policer_pkg::stride_w +: policer_pkg::port_w];
    assign offset   = paddr[policer_pkg::stride_w-1:0];

    assign pready = 1'b1;                              // No wait states.

    // Drops registers are read-only; nothing lives above the last window.
    assign pslverr = access &
                     (~in_range | (pwrite & (offset == policer_pkg::reg_drops)));

    assign wr_en = access & pwrite & ~pslverr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration flops
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge packet_in) begin
        if (rst) begin
            enable    <= '0;
            leak      <= '0;
            threshold <= '0;
        end else if (wr_en) begin
            case (offset)
                policer_pkg::reg_enable: begin
                    enable[port_idx] <= pwdata[0];
                end
                policer_pkg::reg_leak: begin
                    leak[port_idx] <= pwdata[policer_pkg::level_w-1:0];
                end
                policer_pkg::reg_threshold: begin
                    threshold[port_idx] <= pwdata[policer_pkg::length_w-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        prdata = '0;
        if (in_range) begin
            case (offset)
                policer_pkg::reg_enable: begin
                    prdata = 32'(enable[port_idx]);
                end
                policer_pkg::reg_leak: begin
                    prdata = 32'(leak[port_idx]);          // Zero-extended.
                end
                policer_pkg::reg_threshold: begin
                    prdata = 32'(threshold[port_idx]);
                end
                policer_pkg::reg_drops: begin
                    prdata = 32'(drop_count[port_idx]);
                end
                default: begin
                    prdata = '0;                           // Unmapped offset.
                end
            endcase
        end
    end

endmodule

//--- rtl/policer_pkg.sv
// Policer shared constants.
// Port count, field widths and the APB register map.
package policer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream and bucket geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int num_ports = 4;                // Ingress ports policed.
    localparam int port_w    = 2;                // Port number width.
    localparam int data_w    = 32;               // Stream beat width.
    localparam int length_w  = 16;               // Packet byte length.
    localparam int frac_w    = 8;                // Fraction bits of level and leak.
    localparam int level_w   = length_w + frac_w; // Fixed-point bucket level.
    localparam int count_w   = 16;               // Drop counter width.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_w      = 8;              // APB address width.
    localparam int port_stride = 16;             // Bytes per port window.
    localparam int stride_w    = $clog2(port_stride);

    // Offsets inside one port window.
    localparam logic [stride_w-1:0] reg_enable    = 4'd0;
    localparam logic [stride_w-1:0] reg_leak      = 4'd4;
    localparam logic [stride_w-1:0] reg_threshold = 4'd8;
    localparam logic [stride_w-1:0] reg_drops     = 4'd12; // Read-only.

    // First address past the last port window.
    localparam logic [addr_w-1:0] regs_top = 8'(num_ports * port_stride);

endpackage
